// File: list.f
+incdir+include
logic/radio_fe_pkg.sv
logic/rx_frontend.sv
logic/tx_frontend.sv
logic/db_frontend.sv
logic/radio_frontend_core.sv
testbench/tb_clock_gen.sv
testbench/tb_radio_frontend_core.sv

// File: Bender.yml
package:
  name: radio_frontend_core

sources:
  - include_dirs:
      - include
    files:
      - logic/radio_fe_pkg.sv
      - logic/rx_frontend.sv
      - logic/tx_frontend.sv
      - logic/db_frontend.sv
      - logic/radio_frontend_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_radio_frontend_core.sv

// File: testbench/tb_radio_frontend_core.sv
`timescale 1ns/1ps
`include "radio_fe_params.svh"

module tb_radio_frontend_core;

   localparam int CYCLE_LIMIT = 4000;

   logic                    radio_clk;
   logic                    reset;
   logic                    set_stb;
   radio_fe_pkg::chan_sel_t set_chan;
   radio_fe_pkg::set_addr_t set_addr;
   radio_fe_pkg::set_data_t set_data;
   radio_fe_pkg::sample_t   rx_in [2];
   radio_fe_pkg::sample_t   tx_in [2];
   radio_fe_pkg::sample_t   rx_out [4];
   radio_fe_pkg::sample_t   tx_out [2];
   radio_fe_pkg::set_data_t misc_out [2];

   // reference copies of every register the tests write
   radio_fe_pkg::iq_t       rx_off_i [4];
   radio_fe_pkg::iq_t       rx_off_q [4];
   radio_fe_pkg::iq_map_t   rx_map [4];
   radio_fe_pkg::iq_t       tx_off_i [2];
   radio_fe_pkg::iq_t       tx_off_q [2];
   radio_fe_pkg::iq_map_t   tx_mux [2];
   radio_fe_pkg::set_data_t misc_model [2];

   integer seed;
   int     cycle_count = 0;
   bit     failed;

   tb_clock_gen u_clk (.radio_clk(radio_clk), .o_reset(reset));

   radio_frontend_core u_dut (
      .radio_clk   (radio_clk),
      .i_reset     (reset),
      .i_set_stb   (set_stb),
      .i_set_chan  (set_chan),
      .i_set_addr  (set_addr),
      .i_set_data  (set_data),
      .i_rx0       (rx_in[0]),
      .i_rx1       (rx_in[1]),
      .i_tx0       (tx_in[0]),
      .i_tx1       (tx_in[1]),
      .o_rx_ch0    (rx_out[0]),
      .o_rx_ch1    (rx_out[1]),
      .o_rx_ch2    (rx_out[2]),
      .o_rx_ch3    (rx_out[3]),
      .o_tx0       (tx_out[0]),
      .o_tx1       (tx_out[1]),
      .o_misc_out0 (misc_out[0]),
      .o_misc_out1 (misc_out[1])
   );

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // limits of a signed 16 bit component
   function automatic radio_fe_pkg::iq_t clamp_iq(input integer v);
      integer limited;
      limited = v;
      if (v > 32767) begin
         limited = 32767;
      end else if (v < -32768) begin
         limited = -32768;
      end
      return radio_fe_pkg::iq_t'(limited);
   endfunction

   function automatic radio_fe_pkg::sample_t rearrange(input radio_fe_pkg::sample_t s,
                                                       input radio_fe_pkg::iq_map_t code);
      radio_fe_pkg::iq_t upper;
      radio_fe_pkg::iq_t lower;
      radio_fe_pkg::sample_t result;
      upper = s[31:16];
      lower = s[15:0];
      case (code)
         `MAP_SWAP:   result = {lower, upper};
         `MAP_I_ONLY: result = {upper, 16'h0000};
         `MAP_Q_ONLY: result = {lower, 16'h0000};
         default:     result = s;
      endcase
      return result;
   endfunction

   // mapping first, then offset removal
   function automatic radio_fe_pkg::sample_t expected_rx(input radio_fe_pkg::sample_t adc,
                                                         input int ch);
      radio_fe_pkg::sample_t m;
      integer i_val;
      integer q_val;
      m = rearrange(adc, rx_map[ch]);
      i_val = $signed(m[31:16]);
      q_val = $signed(m[15:0]);
      return {clamp_iq(i_val - rx_off_i[ch]), clamp_iq(q_val - rx_off_q[ch])};
   endfunction

   // offset first, then the mux
   function automatic radio_fe_pkg::sample_t expected_tx(input radio_fe_pkg::sample_t s,
                                                         input int b);
      integer i_val;
      integer q_val;
      i_val = $signed(s[31:16]);
      q_val = $signed(s[15:0]);
      return rearrange({clamp_iq(i_val + tx_off_i[b]), clamp_iq(q_val + tx_off_q[b])},
                       tx_mux[b]);
   endfunction

   task automatic update_model(input radio_fe_pkg::chan_sel_t chan,
                               input radio_fe_pkg::set_addr_t addr,
                               input radio_fe_pkg::set_data_t data);
      case (addr)
         `SR_RX_OFFSET_I:   rx_off_i[chan] = data[15:0];
         `SR_RX_OFFSET_Q:   rx_off_q[chan] = data[15:0];
         `SR_RX_IQ_MAPPING: rx_map[chan] = data[1:0];
         `SR_MISC_OUT:      misc_model[chan[1]] = data;   // channel bit ignored
         default: begin
            // tx registers exist on even channels only
            if (!chan[0] && addr == `SR_TX_OFFSET_I) tx_off_i[chan[1]] = data[15:0];
            if (!chan[0] && addr == `SR_TX_OFFSET_Q) tx_off_q[chan[1]] = data[15:0];
            if (!chan[0] && addr == `SR_TX_MUX) tx_mux[chan[1]] = data[1:0];
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // checks and stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic stop_on_failure(input string what);
      failed = 1'b1;
      $display("%s", what);
      $display("Checks failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_sample(input string name, input radio_fe_pkg::sample_t actual,
                               input radio_fe_pkg::sample_t expected);
      if (actual !== expected) begin
         stop_on_failure($sformatf("error %s: got %h, expected %h", name, actual, expected));
      end
   endtask

   task automatic check_data(input string name, input radio_fe_pkg::set_data_t actual,
                             input radio_fe_pkg::set_data_t expected);
      if (actual !== expected) begin
         stop_on_failure($sformatf("error %s: got %h, expected %h", name, actual, expected));
      end
   endtask

   task automatic check_outputs();
      for (int ch = 0; ch < 4; ch++) begin
         check_sample($sformatf("o_rx_ch%0d", ch), rx_out[ch], expected_rx(rx_in[ch / 2], ch));
      end
      check_sample("o_tx0", tx_out[0], expected_tx(tx_in[0], 0));
      check_sample("o_tx1", tx_out[1], expected_tx(tx_in[1], 1));
      check_data("o_misc_out0", misc_out[0], misc_model[0]);
      check_data("o_misc_out1", misc_out[1], misc_model[1]);
   endtask

   task automatic write_setting(input radio_fe_pkg::chan_sel_t chan,
                                input radio_fe_pkg::set_addr_t addr,
                                input radio_fe_pkg::set_data_t data);
      @(negedge radio_clk);
      set_stb  = 1'b1;
      set_chan = chan;
      set_addr = addr;
      set_data = data;
      @(negedge radio_clk);
      set_stb = 1'b0;
      update_model(chan, addr, data);
      repeat (4) @(negedge radio_clk);
   endtask

   // inputs held 4 cycles to cover the 2 cycle latency
   task automatic apply_samples(input radio_fe_pkg::sample_t rx0, input radio_fe_pkg::sample_t rx1,
                                input radio_fe_pkg::sample_t tx0, input radio_fe_pkg::sample_t tx1);
      @(negedge radio_clk);
      rx_in[0] = rx0;
      rx_in[1] = rx1;
      tx_in[0] = tx0;
      tx_in[1] = tx1;
      repeat (4) @(negedge radio_clk);
      check_outputs();
   endtask

   task automatic apply_random();
      radio_fe_pkg::sample_t r [4];
      for (int k = 0; k < 4; k++) begin
         r[k] = $random(seed);
      end
      apply_samples(r[0], r[1], r[2], r[3]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_state_passthrough();
      repeat (20) apply_random();
   endtask

   // offsets written one channel at a time
   task automatic rx_offset_isolation();
      for (int ch = 0; ch < 4; ch++) begin
         write_setting(ch, `SR_RX_OFFSET_I, 32'h0000_4000 + ch * 256);
         write_setting(ch, `SR_RX_OFFSET_Q, 32'h0000_C000 - ch * 512);
         apply_samples(32'h8123_7ABC, 32'h8123_7ABC, tx_in[0], tx_in[1]);  // both clamps
         apply_samples(32'h7FFF_8000, 32'h7FFF_8000, tx_in[0], tx_in[1]);
         apply_samples(32'h0123_FF00, 32'h0123_FF00, tx_in[0], tx_in[1]);
      end
   endtask

   task automatic rx_mapping_codes();
      for (int code = 0; code < 4; code++) begin
         for (int ch = 0; ch < 4; ch++) begin
            write_setting(ch, `SR_RX_IQ_MAPPING, (code + ch) % 4);
         end
         apply_samples(32'h1234_8765, 32'h8765_1234, tx_in[0], tx_in[1]);
         apply_random();
      end
   endtask

   task automatic tx_offset_and_mux();
      radio_fe_pkg::sample_t held;
      for (int b = 0; b < 2; b++) begin
         // board 1 gets the signs swapped so each component clamps both ways
         write_setting(2 * b, `SR_TX_OFFSET_I, b ? 32'h0000_D000 : 32'h0000_3000);
         write_setting(2 * b, `SR_TX_OFFSET_Q, b ? 32'h0000_3000 : 32'h0000_D000);
         for (int code = 0; code < 4; code++) begin
            write_setting(2 * b, `SR_TX_MUX, code);
            apply_samples(rx_in[0], rx_in[1], 32'h6000_A000, 32'h6000_A000);
            apply_samples(rx_in[0], rx_in[1], 32'hA000_6000, 32'hA000_6000);
            apply_samples(rx_in[0], rx_in[1], 32'h0345_FCBA, 32'h0345_FCBA);
         end
      end
      for (int b = 0; b < 2; b++) begin
         held = expected_tx(tx_in[b], b);    // model value before the odd channel writes
         write_setting(2 * b + 1, `SR_TX_OFFSET_I, 32'h0000_1111);
         write_setting(2 * b + 1, `SR_TX_MUX, `MAP_SWAP);
         check_sample($sformatf("o_tx%0d", b), tx_out[b], held);
         check_outputs();
      end
   endtask

   task automatic misc_register_writes();
      radio_fe_pkg::set_addr_t unused [3];
      unused = '{8'd17, 8'd50, 8'd233};
      write_setting(2'd0, `SR_MISC_OUT, 32'hDEAD_BEEF);
      check_outputs();
      write_setting(2'd3, `SR_MISC_OUT, 32'h1234_5678);    // odd channel bit on board 1
      check_outputs();
      foreach (unused[k]) begin
         for (int ch = 0; ch < 4; ch++) begin
            write_setting(ch, unused[k], 32'hFFFF_FFFF);
         end
      end
      apply_samples(rx_in[0], rx_in[1], tx_in[0], tx_in[1]);
   endtask

   // ends a run that stalls
   always @(posedge radio_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         stop_on_failure($sformatf("timeout, tests still running after %0d cycles",
                                   CYCLE_LIMIT));
      end
   end

   initial begin
      seed     = 45996;
      failed   = 1'b0;
      set_stb  = 1'b0;
      set_chan = '0;
      set_addr = '0;
      set_data = '0;
      rx_in    = '{default: '0};
      tx_in    = '{default: '0};
      rx_off_i = '{default: '0};
      rx_off_q = '{default: '0};
      rx_map   = '{default: `MAP_NORMAL};
      tx_off_i = '{default: '0};
      tx_off_q = '{default: '0};
      tx_mux   = '{default: `MAP_NORMAL};
      misc_model = '{default: '0};
      @(negedge radio_clk);
      wait (!reset);
      @(negedge radio_clk);
      reset_state_passthrough();
      rx_offset_isolation();
      rx_mapping_codes();
      tx_offset_and_mux();
      misc_register_writes();
      if (!failed) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

// clock and power-on reset for the testbench
module tb_clock_gen #(
   parameter real PERIOD_NS    = 4.0,
   parameter int  RESET_CYCLES = 2
) (
   output logic radio_clk,
   output logic o_reset
);

   initial begin
      radio_clk = 1'b0;
      forever #(PERIOD_NS / 2.0) radio_clk = ~radio_clk;
   end

   // held over RESET_CYCLES rising edges, released on a falling edge
   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge radio_clk);
      @(negedge radio_clk);
      o_reset = 1'b0;
   end

endmodule

// File: logic/radio_frontend_core.sv
`timescale 1ns/1ps
`include "radio_fe_params.svh"

// radio front-end slice, two daughterboards with two rx channels each
module radio_frontend_core (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   // settings bus, broadcast to both boards
   input  logic                    i_set_stb,
   input  radio_fe_pkg::chan_sel_t i_set_chan,
   input  radio_fe_pkg::set_addr_t i_set_addr,
   input  radio_fe_pkg::set_data_t i_set_data,
   // converters
   input  radio_fe_pkg::sample_t   i_rx0,
   input  radio_fe_pkg::sample_t   i_rx1,
   input  radio_fe_pkg::sample_t   i_tx0,
   input  radio_fe_pkg::sample_t   i_tx1,
   output radio_fe_pkg::sample_t   o_rx_ch0,
   output radio_fe_pkg::sample_t   o_rx_ch1,
   output radio_fe_pkg::sample_t   o_rx_ch2,
   output radio_fe_pkg::sample_t   o_rx_ch3,
   output radio_fe_pkg::sample_t   o_tx0,
   output radio_fe_pkg::sample_t   o_tx1,
   output radio_fe_pkg::set_data_t o_misc_out0,
   output radio_fe_pkg::set_data_t o_misc_out1
);

   // board 0, channels 0 and 1
   db_frontend #(.DB_INDEX(0)) u_db0 (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_chan (i_set_chan),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_adc      (i_rx0),
      .i_tx       (i_tx0),
      .o_rx_a     (o_rx_ch0),
      .o_rx_b     (o_rx_ch1),
      .o_dac      (o_tx0),
      .o_misc_out (o_misc_out0)
   );

   // board 1, channels 2 and 3
   db_frontend #(.DB_INDEX(1)) u_db1 (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_chan (i_set_chan),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_adc      (i_rx1),
      .i_tx       (i_tx1),
      .o_rx_a     (o_rx_ch2),
      .o_rx_b     (o_rx_ch3),
      .o_dac      (o_tx1),
      .o_misc_out (o_misc_out1)
   );

endmodule

// File: logic/db_frontend.sv
`timescale 1ns/1ps
`include "radio_fe_params.svh"

// one daughterboard: settings decode, two rx channels on a shared adc,
// the tx path of the even channel and the misc output register
module db_frontend #(
   parameter int DB_INDEX = 0
) (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  logic                    i_set_stb,
   input  radio_fe_pkg::chan_sel_t i_set_chan,
   input  radio_fe_pkg::set_addr_t i_set_addr,
   input  radio_fe_pkg::set_data_t i_set_data,
   input  radio_fe_pkg::sample_t   i_adc,
   input  radio_fe_pkg::sample_t   i_tx,
   output radio_fe_pkg::sample_t   o_rx_a,
   output radio_fe_pkg::sample_t   o_rx_b,
   output radio_fe_pkg::sample_t   o_dac,
   output radio_fe_pkg::set_data_t o_misc_out
);

   logic                    board_hit;    // strobe aimed at this board
   logic [1:0]              rx_stb_r;     // index is the channel bit
   logic                    misc_stb_r;
   radio_fe_pkg::set_addr_t set_addr_r;
   radio_fe_pkg::set_data_t set_data_r;

   //////////////////////////////////////////////////////////////////////
   // settings decode, one register stage
   //////////////////////////////////////////////////////////////////////

   // upper select bits name the board
   assign board_hit = i_set_stb && (i_set_chan[`CHAN_SEL_WIDTH-1:1] == DB_INDEX);

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         rx_stb_r   <= '0;
         misc_stb_r <= 1'b0;
      end else begin
         rx_stb_r[0] <= board_hit && !i_set_chan[0];
         rx_stb_r[1] <= board_hit && i_set_chan[0];
         // misc register ignores the channel bit
         misc_stb_r  <= board_hit && (i_set_addr == `SR_MISC_OUT);
      end
   end

   always_ff @(posedge radio_clk) begin
      set_addr_r <= i_set_addr;
      set_data_r <= i_set_data;
   end

   //////////////////////////////////////////////////////////////////////
   // front ends
   //////////////////////////////////////////////////////////////////////

   rx_frontend u_rx_a (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set_stb  (rx_stb_r[0]),
      .i_set_addr (set_addr_r),
      .i_set_data (set_data_r),
      .i_adc      (i_adc),
      .o_rx       (o_rx_a)
   );

   rx_frontend u_rx_b (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set_stb  (rx_stb_r[1]),
      .i_set_addr (set_addr_r),
      .i_set_data (set_data_r),
      .i_adc      (i_adc),        // same adc stream as channel a
      .o_rx       (o_rx_b)
   );

   // only the even channel has a tx path, so it shares that strobe
   tx_frontend u_tx (
      .radio_clk  (radio_clk),
      .i_reset    (i_reset),
      .i_set_stb  (rx_stb_r[0]),
      .i_set_addr (set_addr_r),
      .i_set_data (set_data_r),
      .i_tx       (i_tx),
      .o_dac      (o_dac)
   );

   // misc output, drives the pins directly
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out <= '0;
      end else if (misc_stb_r) begin
         o_misc_out <= set_data_r;
      end
   end

endmodule

// File: logic/tx_frontend.sv
`timescale 1ns/1ps
`include "radio_fe_params.svh"

// transmit correction for one channel
// stage one adds the dc offset, stage two is the output mux
module tx_frontend (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  logic                    i_set_stb,
   input  radio_fe_pkg::set_addr_t i_set_addr,
   input  radio_fe_pkg::set_data_t i_set_data,
   input  radio_fe_pkg::sample_t   i_tx,
   output radio_fe_pkg::sample_t   o_dac
);

   radio_fe_pkg::iq_t         offset_i;
   radio_fe_pkg::iq_t         offset_q;
   radio_fe_pkg::iq_map_t     mux_code;     // same encoding as rx mapping

   radio_fe_pkg::iq_t         tx_i;
   radio_fe_pkg::iq_t         tx_q;
   logic signed [`IQ_WIDTH:0] sum_i;
   logic signed [`IQ_WIDTH:0] sum_q;
   radio_fe_pkg::sample_t     corrected;    // stage one output

   //////////////////////////////////////////////////////////////////////
   // settings registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         offset_i <= '0;
         offset_q <= '0;
         mux_code <= `MAP_NORMAL;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_TX_OFFSET_I: begin
               offset_i <= radio_fe_pkg::iq_t'(i_set_data[`IQ_WIDTH-1:0]);
            end
            `SR_TX_OFFSET_Q: begin
               offset_q <= radio_fe_pkg::iq_t'(i_set_data[`IQ_WIDTH-1:0]);
            end
            `SR_TX_MUX: begin
               mux_code <= i_set_data[`IQ_MAP_WIDTH-1:0];
            end
            default: begin
               // ignore anything else on the bus
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage one, offset addition with saturation
   //////////////////////////////////////////////////////////////////////

   assign tx_i  = i_tx[`SAMPLE_WIDTH-1:`IQ_WIDTH];
   assign tx_q  = i_tx[`IQ_WIDTH-1:0];
   assign sum_i = tx_i + offset_i;
   assign sum_q = tx_q + offset_q;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         corrected <= '0;
      end else begin
         corrected <= {radio_fe_pkg::sat_iq(sum_i), radio_fe_pkg::sat_iq(sum_q)};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage two, output mux toward the dac
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_dac <= '0;
      end else begin
         o_dac <= radio_fe_pkg::remap_iq(corrected, mux_code);
      end
   end

endmodule

// File: logic/rx_frontend.sv
`timescale 1ns/1ps
`include "radio_fe_params.svh"

// receive correction for one channel
// stage one maps I/Q, stage two removes the dc offset
module rx_frontend (
   input  logic                    radio_clk,
   input  logic                    i_reset,
   input  logic                    i_set_stb,
   input  radio_fe_pkg::set_addr_t i_set_addr,
   input  radio_fe_pkg::set_data_t i_set_data,
   input  radio_fe_pkg::sample_t   i_adc,
   output radio_fe_pkg::sample_t   o_rx
);

   radio_fe_pkg::iq_t         offset_i;
   radio_fe_pkg::iq_t         offset_q;
   radio_fe_pkg::iq_map_t     iq_mapping;

   radio_fe_pkg::sample_t     mapped;       // stage one output
   radio_fe_pkg::iq_t         mapped_i;
   radio_fe_pkg::iq_t         mapped_q;
   logic signed [`IQ_WIDTH:0] diff_i;       // one guard bit for the clamp
   logic signed [`IQ_WIDTH:0] diff_q;

   //////////////////////////////////////////////////////////////////////
   // settings registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         offset_i   <= '0;
         offset_q   <= '0;
         iq_mapping <= `MAP_NORMAL;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_RX_OFFSET_I: begin
               offset_i <= radio_fe_pkg::iq_t'(i_set_data[`IQ_WIDTH-1:0]);
            end
            `SR_RX_OFFSET_Q: begin
               offset_q <= radio_fe_pkg::iq_t'(i_set_data[`IQ_WIDTH-1:0]);
            end
            `SR_RX_IQ_MAPPING: begin
               iq_mapping <= i_set_data[`IQ_MAP_WIDTH-1:0];
            end
            default: begin
               // other front ends or unused addresses
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage one, I/Q mapping
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         mapped <= '0;
      end else begin
         mapped <= radio_fe_pkg::remap_iq(i_adc, iq_mapping);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage two, offset subtraction with saturation
   //////////////////////////////////////////////////////////////////////

   assign mapped_i = mapped[`SAMPLE_WIDTH-1:`IQ_WIDTH];
   assign mapped_q = mapped[`IQ_WIDTH-1:0];

   // both operands signed, so they sign extend to the guard bit
   assign diff_i = mapped_i - offset_i;
   assign diff_q = mapped_q - offset_q;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rx <= '0;
      end else begin
         o_rx <= {radio_fe_pkg::sat_iq(diff_i), radio_fe_pkg::sat_iq(diff_q)};
      end
   end

endmodule

// File: logic/radio_fe_pkg.sv
`include "radio_fe_params.svh"

package radio_fe_pkg;

   typedef logic signed [`IQ_WIDTH-1:0] iq_t;          // one I or Q component
   typedef logic [`SAMPLE_WIDTH-1:0]    sample_t;      // packed {i, q}
   typedef logic [`SET_ADDR_WIDTH-1:0]  set_addr_t;
   typedef logic [`SET_DATA_WIDTH-1:0]  set_data_t;
   typedef logic [`CHAN_SEL_WIDTH-1:0]  chan_sel_t;
   typedef logic [`IQ_MAP_WIDTH-1:0]    iq_map_t;

   //////////////////////////////////////////////////////////////////////
   // arithmetic shared by both front ends
   //////////////////////////////////////////////////////////////////////

   // clamp a one bit wider sum or difference into the iq_t range
   function automatic iq_t sat_iq(input logic signed [`IQ_WIDTH:0] val);
      iq_t result;
      if (val[`IQ_WIDTH] == val[`IQ_WIDTH-1]) begin
         result = val[`IQ_WIDTH-1:0];                   // no overflow
      end else if (val[`IQ_WIDTH]) begin
         result = {1'b1, {(`IQ_WIDTH-1){1'b0}}};        // most negative
      end else begin
         result = {1'b0, {(`IQ_WIDTH-1){1'b1}}};        // most positive
      end
      return result;
   endfunction

   // rearrange the components of one sample by mapping code
   function automatic sample_t remap_iq(input sample_t s, input iq_map_t code);
      logic [`IQ_WIDTH-1:0] i_part;
      logic [`IQ_WIDTH-1:0] q_part;
      sample_t              result;
      i_part = s[`SAMPLE_WIDTH-1:`IQ_WIDTH];
      q_part = s[`IQ_WIDTH-1:0];
      case (code)
         `MAP_NORMAL: result = {i_part, q_part};
         `MAP_SWAP:   result = {q_part, i_part};
         `MAP_I_ONLY: result = {i_part, {`IQ_WIDTH{1'b0}}};
         `MAP_Q_ONLY: result = {q_part, {`IQ_WIDTH{1'b0}}};
      endcase
      return result;
   endfunction

endpackage

// File: include/radio_fe_params.svh
`ifndef RADIO_FE_PARAMS_SVH
`define RADIO_FE_PARAMS_SVH

// sample layout
`define IQ_WIDTH         16
`define SAMPLE_WIDTH     32     // {i, q}, i in the upper half

// settings bus
`define SET_ADDR_WIDTH   8
`define SET_DATA_WIDTH   32
`define CHAN_SEL_WIDTH   2      // {board, channel on board}

// transmit front-end registers
`define SR_TX_FE_BASE    8'd224
`define SR_TX_OFFSET_I   (`SR_TX_FE_BASE + 8'd0)
`define SR_TX_OFFSET_Q   (`SR_TX_FE_BASE + 8'd1)
`define SR_TX_MUX        (`SR_TX_FE_BASE + 8'd4)

// receive front-end registers
`define SR_RX_FE_BASE    8'd232
`define SR_RX_OFFSET_I   (`SR_RX_FE_BASE + 8'd2)
`define SR_RX_OFFSET_Q   (`SR_RX_FE_BASE + 8'd3)
`define SR_RX_IQ_MAPPING (`SR_RX_FE_BASE + 8'd4)

`define SR_MISC_OUT      8'd16  // one per board

// mapping codes, used by the rx mapping and the tx mux alike
`define IQ_MAP_WIDTH     2
`define MAP_NORMAL       2'd0
`define MAP_SWAP         2'd1
`define MAP_I_ONLY       2'd2
`define MAP_Q_ONLY       2'd3   // q moves up, low half zeroed

`endif
